// ==== list.f ====
hdl/cpu_pkg.sv
hdl/wb_if.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/port_out.sv
hdl/sequencer.sv
hdl/cpu_top.sv
tests/cpu_assert.sv
tests/cpu_tb.sv
+incdir+tests

// ==== Makefile ====
TOOL     = verilator
TOP      = cpu_tb
FILELIST = list.f
FLAGS    = --timing --assert -j 0
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/cpu_model.svh ====
function automatic bit branch_taken(byte_t op, bit cf, bit zf, bit sf, bit of, bit pf);
    bit c;
    case (op[3:1])
        3'd0: c = of;
        3'd1: c = cf;
        3'd2: c = zf;
        3'd3: c = cf | zf;
        3'd4: c = sf;
        3'd5: c = pf;
        3'd6: c = sf ^ of;
        default: c = (sf ^ of) | zf;
    endcase
    return c ^ op[0];       // Odd opcodes negate
endfunction

task automatic model_alu(input int op, input bit w, input int a_in, input int b_in,
                         inout bit cf, output bit zf, output bit sf, output bit of,
                         output bit pf, output int res);
    int mask;
    int top;
    int a;
    int b;
    int r;
    mask = w ? 'hFFFF : 'hFF;
    top  = w ? 15 : 7;
    a    = a_in & mask;
    b    = b_in & mask;
    case (op)
        0: r = a + b;
        2: r = a + b + int'(cf);
        3: r = a - b - int'(cf);
        5, 7: r = a - b;
        1: r = a | b;
        4: r = a & b;
        default: r = a ^ b;
    endcase
    res = r & mask;
    if (op == 0 || op == 2) begin
        cf = r > mask;
        of = (((a >> top) & 1) == ((b >> top) & 1)) && (((res >> top) & 1) != ((a >> top) & 1));
    end else if (op == 3 || op == 5 || op == 7) begin
        cf = r < 0;         // Borrow
        of = (((a >> top) & 1) != ((b >> top) & 1)) && (((res >> top) & 1) != ((a >> top) & 1));
    end else begin
        cf = 1'b0;
        of = 1'b0;
    end
    zf = (res == 0);
    sf = res[top];
    pf = ~^res[7:0];
endtask

task automatic run_model();
    word_t regs [8];
    word_t ip;
    byte_t op;
    byte_t b0;
    bit    cf, zf, sf, of, pf, keep_cf;
    int    res;
    int    steps;
    for (int i = 0; i < 8; i++) regs[i] = '0;
    {cf, zf, sf, of, pf} = '0;
    ip = '0;
    exp_addr_q.delete();
    exp_data_q.delete();
    for (steps = 0; steps < 10000; steps++) begin
        op = mem[ip];
        ip = ip + 1;
        if (op == 8'hF4) break;
        if (op[7:4] == 4'hB) begin
            if (op[3]) begin
                regs[op[2:0]] = {mem[ip + 1], mem[ip]};
                ip = ip + 2;
            end else begin
                if (op[2]) regs[op[1:0]][15:8] = mem[ip];
                else       regs[op[1:0]][7:0]  = mem[ip];
                ip = ip + 1;
            end
        end else if (op[7:6] == 2'b00 && op[2:1] == 2'b10) begin
            if (op[0]) begin
                b0 = mem[ip];
                model_alu(op[5:3], 1'b1, regs[0], {mem[ip + 1], b0}, cf, zf, sf, of, pf, res);
                ip = ip + 2;
                if (op[5:3] != 3'd7) regs[0] = res[15:0];
            end else begin
                model_alu(op[5:3], 1'b0, regs[0], mem[ip], cf, zf, sf, of, pf, res);
                ip = ip + 1;
                if (op[5:3] != 3'd7) regs[0][7:0] = res[7:0];
            end
        end else if (op[7:4] == 4'h4) begin
            keep_cf = cf;
            model_alu(op[3] ? 5 : 0, 1'b1, regs[op[2:0]], 1, cf, zf, sf, of, pf, res);
            cf = keep_cf;
            regs[op[2:0]] = res[15:0];
        end else if (op[7:4] == 4'h7 || op == 8'hEB) begin
            b0 = mem[ip];
            ip = ip + 1;
            if (op == 8'hEB || branch_taken(op, cf, zf, sf, of, pf))
                ip = ip + {{8{b0[7]}}, b0};
        end else if (op == 8'hF8 || op == 8'hF9) begin
            cf = op[0];
        end else if (op == 8'hF5) begin
            cf = ~cf;
        end else if (op == 8'hE6 || op == 8'hE7) begin
            b0 = mem[ip];
            ip = ip + 1;
            exp_addr_q.push_back(b0);
            exp_data_q.push_back(regs[0][7:0]);
            if (op[0]) begin
                exp_addr_q.push_back(b0);
                exp_data_q.push_back(regs[0][15:8]);
            end
        end
    end
    exp_halt = ip;
endtask

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int NUM_PROGS = 6;

    logic  clock = 1'b0;
    logic  rst_n;
    logic  port_credit;
    byte_t i_data;
    word_t o_address;
    byte_t o_port_address;
    byte_t o_port_data;
    logic  o_port_write;
    logic  o_halted;

    byte_t mem [65536];
    byte_t exp_addr_q [$];
    byte_t exp_data_q [$];
    word_t exp_halt;
    int    due_q [$];          // Cycles at which credits go back
    int    cycle = 0;
    int    pos;

    `include "cpu_model.svh"

    cpu_top #(.CREDITS(PORT_CREDITS_DEFAULT)) cpu_top_i (
        .clock          (clock),
        .i_rst_n        (rst_n),
        .i_data         (i_data),
        .i_port_credit  (port_credit),
        .o_address      (o_address),
        .o_port_address (o_port_address),
        .o_port_data    (o_port_data),
        .o_port_write   (o_port_write),
        .o_halted       (o_halted)
    );

    assign i_data = mem[o_address];    // Combinational code memory

    always #10 clock = ~clock;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_port_write(byte_t exp_a, byte_t exp_d, byte_t act_a, byte_t act_d);
        if (exp_a !== act_a || exp_d !== act_d) begin
            $display(
                "CHECK FAILED at %0t: o_port_address/o_port_data expected %02h/%02h got %02h/%02h",
                $time, exp_a, exp_d, act_a, act_d);
            abort_run();
        end
    endtask

    task automatic check_halt(word_t exp_v, word_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED at %0t: o_address expected %04h got %04h",
                     $time, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic emit(byte_t b);
        mem[pos] = b;
        pos++;
    endtask

    // ------------------------------------------------------------------------
    // Random program built from short instruction groups
    // ------------------------------------------------------------------------
    task automatic build_program();
        int    kind;
        int    rem;
        byte_t port;
        byte_t alu_opc;
        for (int a = 0; a < 65536; a++) mem[a] = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5A;
        pos = 0;
        while (pos < 160) begin
            kind = $urandom_range(0, 5);
            port = byte_t'($urandom);
            case (kind)
                0: begin                            // MOV r8 then show AX
                    emit(8'hB0 | byte_t'($urandom_range(0, 7)));
                    emit(byte_t'($urandom));
                    emit(8'hE7);
                    emit(port);
                end
                1: begin
                    emit(8'hB8 | byte_t'($urandom_range(0, 7)));
                    emit(byte_t'($urandom));
                    emit(byte_t'($urandom));
                    emit(8'hE7);
                    emit(port);
                end
                2: begin                            // ALU op with flags seen through Jcc
                    alu_opc = 8'h04 | byte_t'($urandom_range(0, 7) << 3);
                    emit(alu_opc | byte_t'($urandom_range(0, 1)));
                    if (mem[pos - 1][0]) emit(byte_t'($urandom));
                    emit(byte_t'($urandom));
                    emit(8'h70 | byte_t'($urandom_range(0, 15)));
                    emit(8'h02);
                    emit(8'hE6);
                    emit(port);
                    emit(8'hE7);
                    emit(port ^ 8'h01);
                end
                3: begin                            // INC/DEC must keep CF
                    if ($urandom_range(0, 2) == 0) begin
                        emit(8'hF5);
                    end else begin
                        emit(8'hF8 | byte_t'($urandom_range(0, 1)));
                    end
                    emit(8'h40 | byte_t'($urandom_range(0, 15)));
                    emit(8'h72 | byte_t'($urandom_range(0, 1)));
                    emit(8'h02);
                    emit(8'hE6);
                    emit(port);
                    emit(8'hE7);
                    emit(port);
                end
                4: begin                            // Forward skip of 0..6 bytes
                    emit($urandom_range(0, 1) ? 8'hEB : (8'h70 | byte_t'($urandom_range(0, 15))));
                    rem = $urandom_range(0, 6);
                    emit(byte_t'(rem));
                    while (rem >= 2) begin
                        emit(8'hE6);
                        emit(byte_t'($urandom));
                        rem -= 2;
                    end
                    if (rem == 1) emit(8'hF5);
                end
                default: begin
                    emit(8'hE7);
                    emit(port);
                end
            endcase
        end
        emit(8'hF4);
    endtask

    // Port monitor sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && o_port_write) begin
            if (exp_addr_q.size() == 0) begin
                $display("Port write to %02h with data %02h was not expected at %0t",
                         o_port_address, o_port_data, $time);
                abort_run();
            end else begin
                check_port_write(exp_addr_q.pop_front(), exp_data_q.pop_front(),
                                 o_port_address, o_port_data);
                if (due_q.size() == 0 || due_q[$] < cycle + 1)
                    due_q.push_back(cycle + 1 + $urandom_range(0, 5));
                else
                    due_q.push_back(due_q[$] + 1);
            end
        end
    end

    // Credit returner with at most one pulse per cycle
    always @(posedge clock) begin
        cycle <= cycle + 1;
        #1;
        if (!rst_n) begin
            due_q.delete();
            port_credit <= 1'b0;
        end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            port_credit <= 1'b1;
        end else begin
            port_credit <= 1'b0;
        end
    end

    initial begin
        int wait_cnt;
        void'($urandom(42));
        rst_n       = 1'b0;
        port_credit = 1'b0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            rst_n = 1'b0;
            build_program();
            run_model();
            repeat (10) @(posedge clock);
            #1 rst_n = 1'b1;
            wait_cnt = 0;
            while (!o_halted && wait_cnt < 5000) begin
                @(negedge clock);
                wait_cnt++;
            end
            if (!o_halted) begin
                $display("Program %0d did not reach HLT within 5000 cycles", p);
                abort_run();
            end
            check_halt(exp_halt, o_address);
            repeat (50) @(posedge clock);   // Quiet window after HLT
            if (exp_addr_q.size() != 0) begin
                $display("Program %0d ended with %0d port writes missing", p, exp_addr_q.size());
                abort_run();
            end
            #1 rst_n = 1'b0;
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== tests/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert #(
    parameter int CREDITS = 2,
    parameter int CNT_W   = 2
) (
    input logic             clock,
    input logic             i_rst_n,
    input logic [CNT_W-1:0] credit_cnt,
    input logic             o_port_write
);

    // Returned credits never overflow the pool
    a_credit_max: assert property (@(posedge clock) disable iff (!i_rst_n)
        credit_cnt <= CNT_W'(CREDITS))
        else $error("credit count above limit");

    a_write_needs_credit: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_port_write |-> $past(credit_cnt != '0))
        else $error("port write without a free credit");

    a_quiet_in_reset: assert property (@(posedge clock)
        !i_rst_n |=> !o_port_write)
        else $error("port write during reset");

endmodule

bind port_out cpu_assert #(.CREDITS(CREDITS), .CNT_W(CNT_W)) cpu_assert_i (.*);

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int CREDITS = cpu_pkg::PORT_CREDITS_DEFAULT
) (
    input  logic           clock,
    input  logic           i_rst_n,
    input  cpu_pkg::byte_t i_data,          // Byte at o_address
    input  logic           i_port_credit,
    output cpu_pkg::word_t o_address,
    output cpu_pkg::byte_t o_port_address,
    output cpu_pkg::byte_t o_port_data,
    output logic           o_port_write,
    output logic           o_halted
);
    import cpu_pkg::*;

    word_t   regs [8];
    flags_t  flags;

    alu_op_t alu_op;
    logic    alu_word;
    word_t   op1;
    word_t   op2;
    word_t   alu_result;
    flags_t  alu_flags;

    logic    port_req;
    byte_t   port_addr;
    byte_t   port_data;
    logic    port_busy;

    wb_if wb ();

    sequencer sequencer_i (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_data       (i_data),
        .i_regs       (regs),
        .i_flags      (flags),
        .o_alu_op     (alu_op),
        .o_alu_word   (alu_word),
        .o_op1        (op1),
        .o_op2        (op2),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags),
        .o_port_req   (port_req),
        .o_port_addr  (port_addr),
        .o_port_data  (port_data),
        .i_port_busy  (port_busy),
        .o_address    (o_address),
        .o_halted     (o_halted),
        .wb           (wb.driver)
    );

    reg_file reg_file_i (
        .clock   (clock),
        .i_rst_n (i_rst_n),
        .wb      (wb.sink),
        .o_regs  (regs),
        .o_flags (flags)
    );

    alu alu_i (
        .i_op     (alu_op),
        .i_word   (alu_word),
        .i_op1    (op1),
        .i_op2    (op2),
        .i_flags  (flags),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    port_out #(
        .CREDITS (CREDITS)
    ) port_out_i (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_req          (port_req),
        .i_addr         (port_addr),
        .i_data         (port_data),
        .i_credit       (i_port_credit),
        .o_busy         (port_busy),
        .o_port_address (o_port_address),
        .o_port_data    (o_port_data),
        .o_port_write   (o_port_write)
    );

endmodule

// ==== hdl/sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
    input  logic             clock,
    input  logic             i_rst_n,
    input  cpu_pkg::byte_t   i_data,
    input  cpu_pkg::word_t   i_regs [8],
    input  cpu_pkg::flags_t  i_flags,
    output cpu_pkg::alu_op_t o_alu_op,
    output logic             o_alu_word,
    output cpu_pkg::word_t   o_op1,
    output cpu_pkg::word_t   o_op2,
    input  cpu_pkg::word_t   i_alu_result,
    input  cpu_pkg::flags_t  i_alu_flags,
    output logic             o_port_req,
    output cpu_pkg::byte_t   o_port_addr,
    output cpu_pkg::byte_t   o_port_data,
    input  logic             i_port_busy,
    output cpu_pkg::word_t   o_address,
    output logic             o_halted,
    wb_if.driver             wb
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {S_START, S_DECODE, S_IMM, S_PORT, S_HALT} state_t;

    state_t     state;
    word_t      ip;
    byte_t      opcode;
    byte_t      imm_lo;     // First immediate byte or port number
    logic       imm_hi;     // Waiting on the high immediate byte
    logic       out_hi;     // OUT AX now sends AH

    logic       wide_imm;
    logic       taken;
    logic [7:0] cond;
    word_t      next_ip;
    word_t      imm_word;

    // ------------------------------------------------------------------------
    // Opcode classes
    // ------------------------------------------------------------------------
    function automatic logic is_alu(byte_t op);
        return {op[7:6], op[2:1]} == {OP_ALU_AI[7:6], OP_ALU_AI[2:1]};
    endfunction

    function automatic logic is_incdec(byte_t op);
        return op[7:4] == OP_INCDEC[7:4];
    endfunction

    function automatic logic is_jcc(byte_t op);
        return op[7:4] == OP_JCC[7:4];
    endfunction

    function automatic logic is_mov(byte_t op);
        return op[7:4] == OP_MOV_IMM[7:4];
    endfunction

    function automatic logic is_out(byte_t op);
        return op == OP_OUT_B || op == OP_OUT_W;
    endfunction

    function automatic logic has_imm(byte_t op);
        return is_alu(op) || is_jcc(op) || is_mov(op) || is_out(op) || op == OP_JMP8;
    endfunction

    // Branch table indexed by opcode bits 3:1
    assign cond = {
        (i_flags[SF] ^ i_flags[OF]) | i_flags[ZF],  // LE
        i_flags[SF] ^ i_flags[OF],                  // L
        i_flags[PF],
        i_flags[SF],
        i_flags[CF] | i_flags[ZF],                  // BE
        i_flags[ZF],
        i_flags[CF],
        i_flags[OF]
    };

    assign taken    = (opcode == OP_JMP8) || (is_jcc(opcode) && (cond[opcode[3:1]] ^ opcode[0]));
    assign next_ip  = ip + 16'd1;
    assign wide_imm = (is_mov(opcode) && opcode[3]) || (is_alu(opcode) && opcode[0]);
    assign imm_word = wide_imm ? {i_data, imm_lo} : {8'h00, i_data};

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state  <= S_START;
            ip     <= '0;
            opcode <= '0;
            imm_hi <= 1'b0;
            out_hi <= 1'b0;
        end else begin
            case (state)
                S_START: begin
                    imm_hi <= 1'b0;
                    out_hi <= 1'b0;
                    state  <= S_DECODE;
                end
                S_DECODE: begin
                    opcode <= i_data;
                    ip     <= next_ip;
                    if (i_data == OP_HLT) begin
                        state <= S_HALT;
                    end else if (has_imm(i_data)) begin
                        state <= S_IMM;
                    end else begin
                        state <= S_START;       // One-byte ops finish here
                    end
                end
                S_IMM: begin
                    imm_lo <= i_data;
                    if (wide_imm && !imm_hi) begin
                        imm_hi <= 1'b1;
                        ip     <= next_ip;
                    end else begin
                        // Displacement counts from the next instruction
                        ip    <= taken ? next_ip + {{8{i_data[7]}}, i_data} : next_ip;
                        state <= is_out(opcode) ? S_PORT : S_START;
                    end
                end
                S_PORT: begin
                    if (!i_port_busy) begin
                        if (opcode[0] && !out_hi) begin
                            out_hi <= 1'b1;
                        end else begin
                            state <= S_START;
                        end
                    end
                end
                S_HALT: state <= S_HALT;        // Left only through reset
                default: state <= S_START;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Operands and write-back
    // ------------------------------------------------------------------------
    always_comb begin
        o_alu_op   = ALU_ADD;
        o_alu_word = 1'b1;
        o_op1      = i_regs[REG_AX];
        o_op2      = 16'd1;
        wb.wb_en   = 1'b0;
        wb.wb_reg  = REG_AX;
        wb.wb_word = 1'b1;
        wb.wb_data = i_alu_result;
        wb.wf_en   = 1'b0;
        wb.wf_data = i_alu_flags;

        case (state)
            S_DECODE: begin
                if (is_incdec(i_data)) begin
                    o_alu_op       = i_data[3] ? ALU_SUB : ALU_ADD;
                    o_op1          = i_regs[i_data[2:0]];
                    wb.wb_en       = 1'b1;
                    wb.wb_reg      = i_data[2:0];
                    wb.wf_en       = 1'b1;
                    wb.wf_data[CF] = i_flags[CF];   // INC/DEC keep carry
                end else if (i_data == OP_CLC || i_data == OP_STC) begin
                    wb.wf_en       = 1'b1;
                    wb.wf_data     = i_flags;
                    wb.wf_data[CF] = i_data[0];
                end else if (i_data == OP_CMC) begin
                    wb.wf_en       = 1'b1;
                    wb.wf_data     = i_flags;
                    wb.wf_data[CF] = ~i_flags[CF];
                end
            end
            S_IMM: begin
                if (is_alu(opcode)) begin
                    o_alu_op   = alu_op_t'(opcode[5:3]);
                    o_alu_word = opcode[0];
                    o_op2      = imm_word;
                    if (!wide_imm || imm_hi) begin
                        wb.wb_en   = alu_op_t'(opcode[5:3]) != ALU_CMP;
                        wb.wb_word = opcode[0];
                        wb.wf_en   = 1'b1;
                    end
                end else if (is_mov(opcode) && (!wide_imm || imm_hi)) begin
                    wb.wb_en   = 1'b1;
                    wb.wb_reg  = opcode[2:0];
                    wb.wb_word = opcode[3];
                    wb.wb_data = imm_word;
                end
            end
            default: ;
        endcase
    end

    assign o_port_req  = (state == S_PORT) && !i_port_busy;
    assign o_port_addr = imm_lo;
    assign o_port_data = out_hi ? i_regs[REG_AX][15:8] : i_regs[REG_AX][7:0];

    assign o_address = ip;
    assign o_halted  = (state == S_HALT);

endmodule

// ==== hdl/port_out.sv ====
`timescale 1ns/1ps

module port_out #(
    parameter int CREDITS = cpu_pkg::PORT_CREDITS_DEFAULT
) (
    input  logic           clock,
    input  logic           i_rst_n,
    input  logic           i_req,
    input  cpu_pkg::byte_t i_addr,
    input  cpu_pkg::byte_t i_data,
    input  logic           i_credit,
    output logic           o_busy,
    output cpu_pkg::byte_t o_port_address,
    output cpu_pkg::byte_t o_port_data,
    output logic           o_port_write
);
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;   // Credits not yet spent
    logic             spend;

    // Credit is taken at the edge that queues the write
    assign spend  = i_req && !o_busy;
    assign o_busy = (credit_cnt == '0) || o_port_write;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            credit_cnt   <= CNT_W'(CREDITS);
            o_port_write <= 1'b0;
        end else begin
            o_port_write <= spend;
            credit_cnt   <= credit_cnt - CNT_W'(spend) + CNT_W'(i_credit);
        end
    end

    always_ff @(posedge clock) begin
        if (spend) begin
            o_port_address <= i_addr;
            o_port_data    <= i_data;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic            clock,
    input  logic            i_rst_n,
    wb_if.sink              wb,
    output cpu_pkg::word_t  o_regs [8],
    output cpu_pkg::flags_t o_flags
);
    import cpu_pkg::*;

    word_t  regs [8];
    flags_t flags;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags <= FLAGS_RESET;
        end else begin
            if (wb.wb_en) begin
                if (wb.wb_word) begin
                    regs[wb.wb_reg] <= wb.wb_data;
                end else if (wb.wb_reg[2]) begin
                    regs[wb.wb_reg[1:0]][15:8] <= wb.wb_data[7:0];     // AH..BH
                end else begin
                    regs[wb.wb_reg[1:0]][7:0] <= wb.wb_data[7:0];      // AL..BL
                end
            end
            if (wb.wf_en) begin
                flags <= wb.wf_data;
            end
        end
    end

    assign o_regs  = regs;
    assign o_flags = {flags[11:2], 1'b1, flags[0]};    // Bit 1 is always set

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t i_op,
    input  logic             i_word,
    input  cpu_pkg::word_t   i_op1,
    input  cpu_pkg::word_t   i_op2,
    input  cpu_pkg::flags_t  i_flags,
    output cpu_pkg::word_t   o_result,
    output cpu_pkg::flags_t  o_flags
);
    import cpu_pkg::*;

    word_t       a;
    word_t       b;
    logic [16:0] res;
    logic [3:0]  top;       // Sign bit position
    logic        carry;

    // Byte operations see only the low bytes
    assign a     = i_word ? i_op1 : {8'h00, i_op1[7:0]};
    assign b     = i_word ? i_op2 : {8'h00, i_op2[7:0]};
    assign top   = i_word ? 4'd15 : 4'd7;
    assign carry = i_word ? res[16] : res[8];

    always_comb begin
        case (i_op)
            ALU_ADD: res = {1'b0, a} + {1'b0, b};
            ALU_ADC: res = {1'b0, a} + {1'b0, b} + 17'(i_flags[CF]);
            ALU_SBB: res = {1'b0, a} - {1'b0, b} - 17'(i_flags[CF]);
            ALU_SUB,
            ALU_CMP: res = {1'b0, a} - {1'b0, b};
            ALU_XOR: res = {1'b0, a ^ b};
            ALU_OR:  res = {1'b0, a | b};
            ALU_AND: res = {1'b0, a & b};
            default: res = '0;
        endcase
    end

    always_comb begin
        o_flags     = i_flags;
        o_flags[CF] = carry;
        o_flags[AF] = a[4] ^ b[4] ^ res[4];

        case (i_op)
            ALU_ADD,
            ALU_ADC: o_flags[OF] = ~(a[top] ^ b[top]) & (a[top] ^ res[top]);
            ALU_SUB,
            ALU_SBB,
            ALU_CMP: o_flags[OF] = (a[top] ^ b[top]) & (a[top] ^ res[top]);
            default: begin
                // Logic ops
                o_flags[OF] = 1'b0;
                o_flags[CF] = 1'b0;
                o_flags[AF] = res[4];
            end
        endcase

        o_flags[SF] = res[top];
        o_flags[ZF] = i_word ? (res[15:0] == 16'd0) : (res[7:0] == 8'd0);
        o_flags[PF] = ~^res[7:0];   // Even parity of low byte
    end

    assign o_result = res[15:0];

endmodule

// ==== hdl/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;
    import cpu_pkg::*;

    // Register write port
    logic     wb_en;
    reg_idx_t wb_reg;
    logic     wb_word;      // Full 16-bit write when set
    word_t    wb_data;

    // Flag write port
    logic     wf_en;
    flags_t   wf_data;

    modport driver (
        output wb_en, wb_reg, wb_word, wb_data, wf_en, wf_data
    );

    modport sink (
        input wb_en, wb_reg, wb_word, wb_data, wf_en, wf_data
    );

endinterface

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // Basic data types
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [11:0] flags_t;

    // Flag bit positions in the x86 flag word
    localparam int CF = 0;
    localparam int PF = 2;
    localparam int AF = 4;
    localparam int ZF = 6;
    localparam int SF = 7;
    localparam int TF = 8;
    localparam int IF = 9;
    localparam int DF = 10;
    localparam int OF = 11;

    // ALU operations in the order of opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADC = 3'd2,
        ALU_SBB = 3'd3,
        ALU_AND = 3'd4,
        ALU_SUB = 3'd5,
        ALU_XOR = 3'd6,
        ALU_CMP = 3'd7
    } alu_op_t;

    localparam reg_idx_t REG_AX = 3'd0;
    localparam reg_idx_t REG_CX = 3'd1;

    localparam flags_t FLAGS_RESET          = '0;
    localparam int     PORT_CREDITS_DEFAULT = 2;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------
    localparam byte_t OP_ALU_AI  = 8'h04;   // Base of the acc,imm group
    localparam byte_t OP_INCDEC  = 8'h40;   // INC/DEC r16 row
    localparam byte_t OP_JCC     = 8'h70;   // Jcc rel8 row
    localparam byte_t OP_MOV_IMM = 8'hB0;   // MOV r,imm row
    localparam byte_t OP_OUT_B   = 8'hE6;
    localparam byte_t OP_OUT_W   = 8'hE7;
    localparam byte_t OP_JMP8    = 8'hEB;
    localparam byte_t OP_HLT     = 8'hF4;
    localparam byte_t OP_CMC     = 8'hF5;
    localparam byte_t OP_CLC     = 8'hF8;
    localparam byte_t OP_STC     = 8'hF9;

endpackage
